// File: hdl/approx_div_defs.svh
`ifndef APPROX_DIV_DEFS_SVH
`define APPROX_DIV_DEFS_SVH

// Result buffer sizing shared by the RTL and the testbench

`define ADIV_FIFO_DEPTH 4 // Results held between producer and consumer

// Must be wide enough to hold the value ADIV_FIFO_DEPTH itself
`define ADIV_CNT_W 3

`endif

// File: hdl/approx_div_pkg.sv
package approx_div_pkg;

  typedef logic [15:0] dividend_t; // Unsigned dividend
  typedef logic [7:0]  divisor_t;  // Unsigned divisor

  typedef logic [7:0]  quot_t;     // Approximate quotient
  typedef logic [7:0]  rem_t;      // Approximate remainder

  // Buffer word with the quotient in the upper byte and the remainder below
  typedef logic [15:0] div_result_t;

endpackage

// File: hdl/tri_div_array.sv
`timescale 1ns/100ps

module tri_div_array import approx_div_pkg::*; (
  input  dividend_t n,
  input  divisor_t  d,
  output quot_t     q,
  output rem_t      r
);

  // Full subtractor cell that returns {borrow_out, difference}
  function automatic logic [1:0] cell_exact(
    input logic x,
    input logic y,
    input logic b_in
  );
    logic diff;
    logic b_out;
    diff  = x ^ y ^ b_in;
    b_out = (~x & y) | (~(x ^ y) & b_in);
    return {b_out, diff};
  endfunction

  // Approximate cell ignores the divisor bit and never borrows
  function automatic logic [1:0] cell_approx(
    input logic x,
    input logic b_in
  );
    logic diff;
    diff = x & ~b_in;
    return {1'b0, diff};
  endfunction

  wire [7:0] x_cell [0:7]; // Minuend bit entering each cell
  wire [7:0] b_in   [0:7]; // Borrow into each cell
  wire [7:0] b_out  [0:7]; // Borrow out of each cell
  wire [7:0] diff   [0:7]; // Raw subtract result per cell
  wire [7:0] r_part [0:7]; // Partial remainder leaving each row
  wire [7:0] q_row;

  for (genvar i = 0; i < 8; i++) begin : g_row
    for (genvar j = 0; j < 8; j++) begin : g_col

      // Top row reads the dividend directly while lower rows shift in one new bit
      if (i == 7) begin : g_top
        assign x_cell[i][j] = n[7 + j];
      end else if (j == 0) begin : g_shift
        assign x_cell[i][j] = n[i];
      end else begin : g_chain
        assign x_cell[i][j] = r_part[i + 1][j - 1];
      end

      if (j == 0) begin : g_lsb
        assign b_in[i][j] = 1'b0;
      end else begin : g_borrow
        assign b_in[i][j] = b_out[i][j - 1];
      end

      // Low-weight corner of the triangle uses the cheap cell
      if (i + j <= 5) begin : g_approx
        assign {b_out[i][j], diff[i][j]} = cell_approx(x_cell[i][j], b_in[i][j]);
      end else begin : g_exact
        assign {b_out[i][j], diff[i][j]} = cell_exact(x_cell[i][j], d[j], b_in[i][j]);
      end

      assign r_part[i][j] = q_row[i] ? diff[i][j] : x_cell[i][j]; // Restore on failed subtract

    end

    // A set bit above the row or no final borrow means the divisor fits
    if (i == 7) begin : g_q_top
      assign q_row[i] = n[15] | ~b_out[i][7];
    end else begin : g_q_low
      assign q_row[i] = r_part[i + 1][7] | ~b_out[i][7];
    end
  end

  assign q = q_row;
  assign r = r_part[0]; // Bottom row leaves the remainder

endmodule

// File: hdl/div_issue_stage.sv
`timescale 1ns/100ps

module div_issue_stage import approx_div_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        in_valid,
  input  dividend_t   n,
  input  divisor_t    d,
  input  logic        busy,
  output logic        issue_valid,
  output div_result_t issue_result,
  output logic        overflow
);

  quot_t arr_q;
  rem_t  arr_r;
  logic  accept;

  tri_div_array u_tri_div_array (
    .n (n),
    .d (d),
    .q (arr_q),
    .r (arr_r)
  );

  assign accept = in_valid & ~busy; // Buffer has room for one more result

  always_ff @(posedge clk) begin
    if (rst) begin
      issue_valid <= 1'b0;
      overflow    <= 1'b0;
    end else begin
      issue_valid <= accept;
      if (in_valid && busy) begin
        overflow <= 1'b1; // Sticky until reset
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      issue_result <= {arr_q, arr_r};
    end
  end

endmodule

// File: hdl/div_result_fifo.sv
`timescale 1ns/100ps

`include "approx_div_defs.svh"

module div_result_fifo import approx_div_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        push,
  input  div_result_t push_data,
  input  logic        pop,
  output div_result_t pop_data,
  output logic        empty,
  output logic        busy
);

  localparam int PTR_W = (`ADIV_FIFO_DEPTH > 1) ? $clog2(`ADIV_FIFO_DEPTH) : 1;

  div_result_t mem [`ADIV_FIFO_DEPTH];

  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [`ADIV_CNT_W-1:0] count;
  logic [`ADIV_CNT_W:0]   fill; // Occupancy including the result now arriving

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(`ADIV_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`ADIV_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + `ADIV_CNT_W'(push) - `ADIV_CNT_W'(pop);
    end
  end

  assign pop_data = mem[rd_ptr];
  assign empty    = (count == '0);

  // An operand accepted now lands one cycle later, so count it as already here
  assign fill = {1'b0, count} + {{`ADIV_CNT_W{1'b0}}, push};
  assign busy = (fill >= (`ADIV_CNT_W + 1)'(`ADIV_FIFO_DEPTH));

endmodule

// File: hdl/div_result_port.sv
`timescale 1ns/100ps

module div_result_port import approx_div_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        out_req,
  input  logic        empty,
  input  div_result_t pop_data,
  output logic        pop,
  output logic        out_valid,
  output quot_t       q,
  output rem_t        r
);

  assign pop = out_req & ~empty; // Requests on an empty buffer are dropped

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= pop; // Single cycle pulse per popped word
    end
  end

  // Result stays on q and r until the next pop
  always_ff @(posedge clk) begin
    if (pop) begin
      q <= pop_data[15:8];
      r <= pop_data[7:0];
    end
  end

endmodule

// File: hdl/approx_div_top.sv
`timescale 1ns/100ps

module approx_div_top import approx_div_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      in_valid,
  input  dividend_t n,
  input  divisor_t  d,
  output logic      busy,
  output logic      overflow,
  input  logic      out_req,
  output logic      out_valid,
  output quot_t     q,
  output rem_t      r
);

  logic        issue_valid;
  div_result_t issue_result;
  logic        pop;
  div_result_t pop_data;
  logic        empty;

  div_issue_stage u_div_issue_stage (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .n            (n),
    .d            (d),
    .busy         (busy),
    .issue_valid  (issue_valid),
    .issue_result (issue_result),
    .overflow     (overflow)
  );

  div_result_fifo u_div_result_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (issue_valid),
    .push_data (issue_result),
    .pop       (pop),
    .pop_data  (pop_data),
    .empty     (empty),
    .busy      (busy)
  );

  div_result_port u_div_result_port (
    .clk       (clk),
    .rst       (rst),
    .out_req   (out_req),
    .empty     (empty),
    .pop_data  (pop_data),
    .pop       (pop),
    .out_valid (out_valid),
    .q         (q),
    .r         (r)
  );

endmodule

// File: verification/approx_div_props.sv
`timescale 1ns/100ps

`include "approx_div_defs.svh"

module approx_div_props (
  input logic                   clk,
  input logic                   rst,
  input logic                   push,
  input logic                   pop,
  input logic                   empty,
  input logic [`ADIV_CNT_W-1:0] count,
  input logic                   out_req,
  input logic                   out_valid,
  input logic                   overflow
);

  // A push into a full buffer would overwrite the oldest result
  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    push |-> (count < `ADIV_FIFO_DEPTH))
    else $error("push while the result buffer is full");

  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
    pop |-> !empty)
    else $error("pop while the result buffer is empty");

  a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_req) |=> !out_valid) // Valid drops unless another word is requested
    else $error("out_valid stayed high without a new request");

  a_overflow_sticky: assert property (@(posedge clk) disable iff (rst)
    (!$past(rst) && $past(overflow)) |-> overflow)
    else $error("overflow fell without a reset");

endmodule

bind div_result_fifo approx_div_props u_fifo_props (
  .clk       (clk),
  .rst       (rst),
  .push      (push),
  .pop       (pop),
  .empty     (empty),
  .count     (count),
  .out_req   (1'b0),
  .out_valid (1'b0),
  .overflow  (1'b0)
);

bind div_result_port approx_div_props u_port_props (
  .clk       (clk),
  .rst       (rst),
  .push      (1'b0),
  .pop       (1'b0),
  .empty     (1'b0),
  .count     ('0),
  .out_req   (out_req),
  .out_valid (out_valid),
  .overflow  (1'b0)
);

// The overflow flag lives in the producer
bind div_issue_stage approx_div_props u_issue_props (
  .clk       (clk),
  .rst       (rst),
  .push      (1'b0),
  .pop       (1'b0),
  .empty     (1'b0),
  .count     ('0),
  .out_req   (1'b0),
  .out_valid (1'b0),
  .overflow  (overflow)
);

// File: verification/approx_div_tb.sv
`timescale 1ns/100ps

`include "approx_div_defs.svh"

module approx_div_tb import approx_div_pkg::*; ();

  logic      clk;
  logic      rst;
  logic      in_valid;
  dividend_t n;
  divisor_t  d;
  logic      out_req;
  logic      busy;
  logic      overflow;
  logic      out_valid;
  quot_t     q;
  rem_t      r;

  logic [23:0] exp_q [$]; // Accepted {dividend, divisor} pairs in issue order
  string       test_name;
  int          test_errs;
  int          err_cnt;
  int          tests_run;
  int          tests_failed;
  int          seen_valid;

  approx_div_top u_approx_div_top (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .n         (n),
    .d         (d),
    .busy      (busy),
    .overflow  (overflow),
    .out_req   (out_req),
    .out_valid (out_valid),
    .q         (q),
    .r         (r)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Walks the triangular array row by row from the top
  function automatic div_result_t ref_div(input dividend_t nn, input divisor_t dd);
    logic [7:0] x;
    logic [7:0] diff;
    logic [7:0] part;
    logic       upper;
    logic       borrow;
    logic       q_bit;
    quot_t      quo;
    int         sub;
    part = '0;
    quo  = '0;
    for (int i = 7; i >= 0; i--) begin
      if (i == 7) begin
        x     = nn[14:7];
        upper = nn[15];
      end else begin
        x     = {part[6:0], nn[i]};
        upper = part[7];
      end
      borrow = 1'b0;
      for (int j = 0; j < 8; j++) begin
        if (i + j <= 5) begin
          diff[j] = x[j] & ~borrow;
          borrow  = 1'b0;
        end else begin
          sub     = int'(x[j]) - int'(dd[j]) - int'(borrow); // One bit of x - y - b
          diff[j] = sub[0];
          borrow  = (sub < 0);
        end
      end
      q_bit  = upper | ~borrow;
      quo[i] = q_bit;
      part   = q_bit ? diff : x;
    end
    return {quo, part};
  endfunction

  task automatic expect_level(input string what, input int expected, input int actual);
    if (actual != expected) begin
      $display("Error %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
      test_errs++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    err_cnt += test_errs;
    if (test_errs == 0) begin
      $display("Test %s passed", test_name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", test_name, test_errs);
    end
  endtask

  task automatic idle_cycles(input int cycles);
    repeat (cycles) @(posedge clk);
    #1;
  endtask

  task automatic apply_reset();
    rst      = 1'b1;
    in_valid = 1'b0;
    out_req  = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    exp_q.delete();
  endtask

  // Called just after a rising edge, returns just after the next one
  task automatic send_operands(input dividend_t nn, input divisor_t dd);
    in_valid = 1'b1;
    n        = nn;
    d        = dd;
    if (!busy) begin
      exp_q.push_back({nn, dd});
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic wait_drain(input int limit);
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < limit) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout in %s: %0d results never came out", test_name, exp_q.size());
      test_errs++;
      exp_q.delete();
    end
  endtask

  // Scoreboard compare sampled mid-cycle at the falling edge
  initial begin
    logic [23:0] ops;
    div_result_t want;
    forever begin
      @(negedge clk);
      if (!rst && out_valid) begin
        seen_valid++;
        if (exp_q.size() == 0) begin
          $display("Error in %s: out_valid rose with no result outstanding", test_name);
          test_errs++;
        end else begin
          ops  = exp_q.pop_front();
          want = ref_div(ops[23:8], ops[7:0]);
          if ({q, r} !== want) begin
            $display("Error %s: n=%h d=%h expected q=%h r=%h, actual q=%h r=%h",
                     test_name, ops[23:8], ops[7:0], want[15:8], want[7:0], q, r);
            test_errs++;
          end
        end
      end
    end
  end

  initial begin
    int accepted;
    int guard;
    int start_valid;
    rst          = 1'b1;
    in_valid     = 1'b0;
    n            = '0;
    d            = '0;
    out_req      = 1'b0;
    test_name    = "init";
    test_errs    = 0;
    err_cnt      = 0;
    tests_run    = 0;
    tests_failed = 0;
    seen_valid   = 0;
    void'($urandom(32'h32675363));
    apply_reset();

    begin_test("directed");
    out_req     = 1'b1;
    start_valid = seen_valid;
    send_operands(16'h0000, 8'h00);
    send_operands(16'hffff, 8'hff);
    send_operands(16'hffff, 8'h01);
    send_operands(16'h04d2, 8'h01);
    send_operands(16'hc350, 8'hff);
    send_operands(16'h00ff, 8'hff);
    send_operands(16'h8000, 8'h80);
    wait_drain(50);
    expect_level("results returned", 7, seen_valid - start_valid);
    end_test();

    begin_test("random_stream");
    start_valid = seen_valid;
    repeat (300) send_operands(dividend_t'($urandom()), divisor_t'($urandom()));
    wait_drain(100);
    expect_level("results returned", 300, seen_valid - start_valid);
    expect_level("overflow", 0, overflow);
    end_test();

    begin_test("fill_buffer");
    out_req = 1'b0;
    idle_cycles(2);
    start_valid = seen_valid;
    accepted    = 0;
    guard       = 0;
    while (!busy && guard < 4 * `ADIV_FIFO_DEPTH) begin
      send_operands(dividend_t'($urandom()), divisor_t'($urandom()));
      accepted++;
      guard++;
    end
    if (!busy) begin
      $display("Error in %s: busy never rose with requests held off", test_name);
      test_errs++;
    end
    expect_level("accepted operands", `ADIV_FIFO_DEPTH, accepted);
    expect_level("overflow", 0, overflow);
    end_test();

    begin_test("overflow_drop");
    send_operands(16'h1234, 8'h56); // Refused while the buffer is busy
    expect_level("overflow", 1, overflow);
    out_req = 1'b1;
    wait_drain(50);
    idle_cycles(4);
    expect_level("results after refill", `ADIV_FIFO_DEPTH, seen_valid - start_valid);
    expect_level("overflow", 1, overflow);
    end_test();

    begin_test("random_handshake");
    repeat (400) begin
      out_req = 1'($urandom() % 2);
      if ($urandom() % 3 != 0) begin
        send_operands(dividend_t'($urandom()), divisor_t'($urandom()));
      end else begin
        idle_cycles(1);
      end
    end
    out_req = 1'b1;
    wait_drain(100);
    end_test();

    begin_test("reset_idle");
    apply_reset();
    expect_level("busy", 0, busy);
    expect_level("overflow", 0, overflow);
    expect_level("out_valid", 0, out_valid);
    start_valid = seen_valid;
    out_req     = 1'b1;
    idle_cycles(10);
    expect_level("out_valid pulses on empty buffer", 0, seen_valid - start_valid);
    out_req = 1'b0;
    end_test();

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (tests_failed == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+hdl
hdl/approx_div_pkg.sv
hdl/tri_div_array.sv
hdl/div_issue_stage.sv
hdl/div_result_fifo.sv
hdl/div_result_port.sv
hdl/approx_div_top.sv
verification/approx_div_props.sv
verification/approx_div_tb.sv

// File: Bender.yml
package:
  name: approx_div

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/approx_div_pkg.sv
      - hdl/tri_div_array.sv
      - hdl/div_issue_stage.sv
      - hdl/div_result_fifo.sv
      - hdl/div_result_port.sv
      - hdl/approx_div_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/approx_div_props.sv
      - verification/approx_div_tb.sv
